/* rtl/x4xx_core_config.svh */
// x4xx core configuration macros
// board count, address map, register offsets and reset values
`ifndef X4XX_CORE_CONFIG_SVH
`define X4XX_CORE_CONFIG_SVH

// --------------------
// sizes
`define X4XX_NUM_DBOARDS     2
`define X4XX_CTRLPORT_ADDR_W 20

// --------------------
// address map, byte addresses
// motherboard and timekeeper each own a 4 KB window
`define X4XX_MB_BASE     20'h00000
`define X4XX_TK_BASE     20'h01000
// one 256 KB window per daughterboard, db0 at 0x80000
`define X4XX_DB_BASE     20'h80000
`define X4XX_DB_WINDOW_W 18

// motherboard register offsets
`define X4XX_REG_COMPAT     20'h00000
`define X4XX_REG_DEVICE_ID  20'h00004
`define X4XX_REG_SCRATCH    20'h00008
`define X4XX_REG_PPS_SELECT 20'h0000C

// timekeeper register offsets
`define X4XX_REG_TIME_SET_LO 20'h00000
`define X4XX_REG_TIME_SET_HI 20'h00004
`define X4XX_REG_TIME_NOW_LO 20'h00008
`define X4XX_REG_TIME_NOW_HI 20'h0000C

// constant and reset values
`define X4XX_COMPAT_NUM      32'h00070001
`define X4XX_DEVICE_ID_RESET 16'h0000

`endif

/* rtl/x4xx_core_pkg.sv */
// ctrlport types for the x4xx core
// request struct, response struct and response status
`include "x4xx_core_config.svh"

package x4xx_core_pkg;

  // --------------------
  // response status codes
  typedef enum logic [1:0] {
    sts_okay   = 2'b00,
    sts_cmderr = 2'b01,  // bad command or unmapped address
    sts_tsterr = 2'b10,  // timestamp problem
    sts_slverr = 2'b11   // target side error
  } ctrlport_status_t;

  // --------------------
  // request, wr and rd are one-cycle pulses
  typedef struct packed {
    logic                             wr;
    logic                             rd;
    logic [`X4XX_CTRLPORT_ADDR_W-1:0] addr;
    logic [31:0]                      data;
    logic [3:0]                       byte_en;
    logic                             has_time;   // hold until timestamp
    logic [63:0]                      timestamp;  // radio time to execute at
  } ctrlport_req_t;

  // --------------------
  // response, one ack pulse per request
  typedef struct packed {
    logic             ack;
    ctrlport_status_t status;
    logic [31:0]      data;    // read data
  } ctrlport_resp_t;

endpackage

/* rtl/x4xx_ctrlport_decoder.sv */
// ctrlport address decoder
// routes each request to motherboard regs, timekeeper or one board port
// strips the window base and returns exactly one response
`timescale 1ns/1ps
`include "x4xx_core_config.svh"

module x4xx_ctrlport_decoder (
  input  logic                                                  radio_clk,
  input  logic                                                  rst_n,
  input  x4xx_core_pkg::ctrlport_req_t                          s_req,
  output x4xx_core_pkg::ctrlport_resp_t                         s_resp,
  output x4xx_core_pkg::ctrlport_req_t                          mb_req,
  input  x4xx_core_pkg::ctrlport_resp_t                         mb_resp,
  output x4xx_core_pkg::ctrlport_req_t                          tk_req,
  input  x4xx_core_pkg::ctrlport_resp_t                         tk_resp,
  output x4xx_core_pkg::ctrlport_req_t  [`X4XX_NUM_DBOARDS-1:0] db_req,
  input  x4xx_core_pkg::ctrlport_resp_t [`X4XX_NUM_DBOARDS-1:0] db_resp
);

  localparam int num_db    = `X4XX_NUM_DBOARDS;
  localparam int aw        = `X4XX_CTRLPORT_ADDR_W;
  localparam int reg_win_w = 12;  // 4 KB register windows
  localparam int sel_w     = (num_db > 1) ? $clog2(num_db) : 1;

  localparam logic [aw-1:0] mb_base = `X4XX_MB_BASE;
  localparam logic [aw-1:0] tk_base = `X4XX_TK_BASE;
  localparam logic [aw-1:0] db_base = `X4XX_DB_BASE;

  typedef enum logic [1:0] {tgt_none, tgt_mb, tgt_tk, tgt_db} target_t;

  logic                          accept;
  logic                          hit_mb;
  logic                          hit_tk;
  logic                          hit_db;
  logic                          hit_any;
  logic [aw-1:0]                 db_off;
  logic [aw-1:0]                 db_idx;
  logic                          done;        // outstanding target acked
  logic [num_db+1:0]             go_d;        // bit 0 mb, bit 1 tk, then boards
  logic [num_db+1:0]             go_q;
  target_t                       tgt_q;
  logic [sel_w-1:0]              db_sel_q;
  x4xx_core_pkg::ctrlport_req_t  fwd_d;
  x4xx_core_pkg::ctrlport_req_t  fwd_q;
  x4xx_core_pkg::ctrlport_resp_t resp_d;
  x4xx_core_pkg::ctrlport_resp_t resp_q;

  // keeps the payload, lets wr/rd through only toward the selected target
  function automatic x4xx_core_pkg::ctrlport_req_t gate_req(
    x4xx_core_pkg::ctrlport_req_t req,
    logic                         en
  );
    x4xx_core_pkg::ctrlport_req_t r;
    r    = req;
    r.wr = req.wr & en;
    r.rd = req.rd & en;
    return r;
  endfunction

  // --------------------
  // address decode
  assign accept  = (s_req.wr | s_req.rd) && (tgt_q == tgt_none);
  assign hit_mb  = s_req.addr[aw-1:reg_win_w] == mb_base[aw-1:reg_win_w];
  assign hit_tk  = s_req.addr[aw-1:reg_win_w] == tk_base[aw-1:reg_win_w];
  assign db_off  = s_req.addr - db_base;
  assign db_idx  = db_off >> `X4XX_DB_WINDOW_W;
  assign hit_db  = (s_req.addr >= db_base) && (db_idx < aw'(num_db));
  assign hit_any = hit_mb | hit_tk | hit_db;

  always_comb begin
    fwd_d = s_req;
    if (hit_db)
      fwd_d.addr = aw'(db_off[`X4XX_DB_WINDOW_W-1:0]);
    else
      fwd_d.addr = aw'(s_req.addr[reg_win_w-1:0]);  // offset in 4 KB window
  end

  always_comb begin
    go_d = '0;
    if (accept) begin
      go_d[0] = hit_mb;
      go_d[1] = hit_tk;
      for (int n = 0; n < num_db; n++)
        go_d[2+n] = hit_db && (db_idx == aw'(n));
    end
  end

  // --------------------
  // request register and target tracking
  always_ff @(posedge radio_clk) begin
    if (accept) begin
      fwd_q    <= fwd_d;
      db_sel_q <= sel_w'(db_idx);
    end
  end

  always_ff @(posedge radio_clk) begin
    if (!rst_n) begin
      go_q  <= '0;
      tgt_q <= tgt_none;
    end else begin
      go_q <= go_d;
      if (accept && hit_mb)
        tgt_q <= tgt_mb;
      else if (accept && hit_tk)
        tgt_q <= tgt_tk;
      else if (accept && hit_db)
        tgt_q <= tgt_db;
      else if (done)
        tgt_q <= tgt_none;
    end
  end

  assign mb_req = gate_req(fwd_q, go_q[0]);
  assign tk_req = gate_req(fwd_q, go_q[1]);

  always_comb begin
    for (int n = 0; n < num_db; n++)
      db_req[n] = gate_req(fwd_q, go_q[2+n]);
  end

  // --------------------
  // response path
  always_comb begin
    resp_d = '0;
    done   = 1'b0;
    case (tgt_q)
      tgt_mb: begin
        resp_d = mb_resp;
        done   = mb_resp.ack;
      end
      tgt_tk: begin
        resp_d = tk_resp;
        done   = tk_resp.ack;
      end
      tgt_db: done = db_resp[db_sel_q].ack;
      default: begin
        resp_d.ack    = accept & ~hit_any;  // unmapped, answered here
        resp_d.status = x4xx_core_pkg::sts_cmderr;
      end
    endcase
  end

  always_ff @(posedge radio_clk) begin
    resp_q <= resp_d;
    if (!rst_n)
      resp_q.ack <= 1'b0;
  end

  // board responses come already registered from the gate
  always_comb begin
    s_resp = resp_q;
    if (tgt_q == tgt_db)
      s_resp = db_resp[db_sel_q];
  end

endmodule

/* rtl/x4xx_mb_regs.sv */
// motherboard register file
// compat number, device id, scratch and pps select, byte-enable writes
`timescale 1ns/1ps
`include "x4xx_core_config.svh"

module x4xx_mb_regs (
  input  logic                          radio_clk,
  input  logic                          rst_n,
  input  x4xx_core_pkg::ctrlport_req_t  req,
  output x4xx_core_pkg::ctrlport_resp_t resp,
  output logic [15:0]                   device_id,
  output logic [1:0]                    pps_select
);

  logic [31:0] scratch;
  logic [31:0] rd_data;

  // --------------------
  // read mux
  always_comb begin
    case (req.addr)
      `X4XX_REG_COMPAT:     rd_data = `X4XX_COMPAT_NUM;
      `X4XX_REG_DEVICE_ID:  rd_data = {16'b0, device_id};
      `X4XX_REG_SCRATCH:    rd_data = scratch;
      `X4XX_REG_PPS_SELECT: rd_data = {30'b0, pps_select};
      default:              rd_data = '0;  // unknown offsets read zero
    endcase
  end

  // --------------------
  // writes
  always_ff @(posedge radio_clk) begin
    if (!rst_n) begin
      device_id  <= `X4XX_DEVICE_ID_RESET;
      scratch    <= '0;
      pps_select <= '0;
    end else if (req.wr) begin
      case (req.addr)
        `X4XX_REG_DEVICE_ID:
          for (int b = 0; b < 2; b++)
            if (req.byte_en[b])
              device_id[8*b +: 8] <= req.data[8*b +: 8];
        `X4XX_REG_SCRATCH:
          for (int b = 0; b < 4; b++)
            if (req.byte_en[b])
              scratch[8*b +: 8] <= req.data[8*b +: 8];
        `X4XX_REG_PPS_SELECT:
          if (req.byte_en[0])
            pps_select <= req.data[1:0];
        default: ;
      endcase
    end
  end

  // one-cycle response, always okay
  always_ff @(posedge radio_clk) begin
    resp.ack    <= req.wr | req.rd;
    resp.status <= x4xx_core_pkg::sts_okay;
    resp.data   <= req.rd ? rd_data : '0;
    if (!rst_n)
      resp.ack <= 1'b0;
  end

endmodule

/* rtl/x4xx_timekeeper.sv */
// timekeeper
// 64-bit radio time counted from strobes
// set registers (lo pending, hi loads) and snapshot read registers
`timescale 1ns/1ps
`include "x4xx_core_config.svh"

module x4xx_timekeeper (
  input  logic                          radio_clk,
  input  logic                          rst_n,
  input  x4xx_core_pkg::ctrlport_req_t  req,
  input  logic                          time_stb,
  output x4xx_core_pkg::ctrlport_resp_t resp,
  output logic [63:0]                   radio_time
);

  logic [31:0] set_lo;   // pending low word
  logic [31:0] snap_hi;  // high word captured on a NOW_LO read
  logic [31:0] rd_data;
  logic        set_hi;

  assign set_hi = req.wr && (req.addr == `X4XX_REG_TIME_SET_HI);

  // --------------------
  // time counter
  always_ff @(posedge radio_clk) begin
    if (!rst_n)
      radio_time <= '0;
    else if (set_hi)
      radio_time <= {req.data, set_lo};  // load wins over the increment
    else if (time_stb)
      radio_time <= radio_time + 64'd1;
  end

  always_ff @(posedge radio_clk) begin
    if (req.wr && (req.addr == `X4XX_REG_TIME_SET_LO))
      set_lo <= req.data;
    if (req.rd && (req.addr == `X4XX_REG_TIME_NOW_LO))
      snap_hi <= radio_time[63:32];
  end

  // --------------------
  // readback, byte enables not used here
  always_comb begin
    case (req.addr)
      `X4XX_REG_TIME_NOW_LO: rd_data = radio_time[31:0];
      `X4XX_REG_TIME_NOW_HI: rd_data = snap_hi;
      default:               rd_data = '0;
    endcase
  end

  always_ff @(posedge radio_clk) begin
    resp.ack    <= req.wr | req.rd;
    resp.status <= x4xx_core_pkg::sts_okay;
    resp.data   <= req.rd ? rd_data : '0;
    if (!rst_n)
      resp.ack <= 1'b0;
  end

endmodule

/* rtl/x4xx_radio_ctrlport_gate.sv */
// per-daughterboard ctrlport gate
// holds one request, releases it when untimed or when its time is reached
// registers the board response back toward the decoder
`timescale 1ns/1ps

module x4xx_radio_ctrlport_gate (
  input  logic                          radio_clk,
  input  logic                          rst_n,
  input  x4xx_core_pkg::ctrlport_req_t  s_req,
  output x4xx_core_pkg::ctrlport_resp_t s_resp,
  input  logic [63:0]                   radio_time,
  output x4xx_core_pkg::ctrlport_req_t  m_req,
  input  x4xx_core_pkg::ctrlport_resp_t m_resp
);

  x4xx_core_pkg::ctrlport_req_t held_q;
  logic                         pend_q;  // request held, not yet released
  logic                         wait_q;  // released, board ack outstanding
  logic                         due;
  logic                         fire;

  // --------------------
  // release condition
  // late timestamps go out right away
  assign due  = !held_q.has_time || (radio_time >= held_q.timestamp);
  assign fire = pend_q & due;

  always_comb begin
    m_req    = held_q;
    m_req.wr = held_q.wr & fire;  // single-cycle pulse
    m_req.rd = held_q.rd & fire;
  end

  always_ff @(posedge radio_clk) begin
    if (s_req.wr | s_req.rd)
      held_q <= s_req;
  end

  // --------------------
  // control state and response
  always_ff @(posedge radio_clk) begin
    s_resp     <= m_resp;
    s_resp.ack <= m_resp.ack & wait_q;
    if (!rst_n) begin
      pend_q     <= 1'b0;
      wait_q     <= 1'b0;
      s_resp.ack <= 1'b0;
    end else begin
      if (s_req.wr | s_req.rd)
        pend_q <= 1'b1;
      else if (fire)
        pend_q <= 1'b0;

      if (fire)
        wait_q <= 1'b1;
      else if (m_resp.ack)
        wait_q <= 1'b0;
    end
  end

endmodule

/* rtl/x4xx_core.sv */
// x4xx core control path, single radio_clk domain
// decoder, motherboard registers, timekeeper and one timed gate per board
`timescale 1ns/1ps
`include "x4xx_core_config.svh"

module x4xx_core (
  input  logic                                                  radio_clk,
  input  logic                                                  rst_n,
  // ctrlport from the host side
  input  x4xx_core_pkg::ctrlport_req_t                          s_ctrlport_req,
  output x4xx_core_pkg::ctrlport_resp_t                         s_ctrlport_resp,
  // radio strobes and time
  input  logic [`X4XX_NUM_DBOARDS*2-1:0]                        rx_stb,
  output logic [63:0]                                           radio_time,
  output logic                                                  radio_time_stb,
  // board level settings
  output logic [15:0]                                           device_id,
  output logic [1:0]                                            pps_select,
  // radio ctrlport, one per daughterboard
  output x4xx_core_pkg::ctrlport_req_t  [`X4XX_NUM_DBOARDS-1:0] m_ctrlport_radio_req,
  input  x4xx_core_pkg::ctrlport_resp_t [`X4XX_NUM_DBOARDS-1:0] m_ctrlport_radio_resp
);

  x4xx_core_pkg::ctrlport_req_t                          mb_req;
  x4xx_core_pkg::ctrlport_resp_t                         mb_resp;
  x4xx_core_pkg::ctrlport_req_t                          tk_req;
  x4xx_core_pkg::ctrlport_resp_t                         tk_resp;
  x4xx_core_pkg::ctrlport_req_t  [`X4XX_NUM_DBOARDS-1:0] db_req;
  x4xx_core_pkg::ctrlport_resp_t [`X4XX_NUM_DBOARDS-1:0] db_resp;

  // first rx strobe doubles as the time strobe
  assign radio_time_stb = rx_stb[0];

  // --------------------
  // request routing
  x4xx_ctrlport_decoder decoder_i (
    .radio_clk (radio_clk),
    .rst_n     (rst_n),
    .s_req     (s_ctrlport_req),
    .s_resp    (s_ctrlport_resp),
    .mb_req    (mb_req),
    .mb_resp   (mb_resp),
    .tk_req    (tk_req),
    .tk_resp   (tk_resp),
    .db_req    (db_req),
    .db_resp   (db_resp)
  );

  x4xx_mb_regs mb_regs_i (
    .radio_clk  (radio_clk),
    .rst_n      (rst_n),
    .req        (mb_req),
    .resp       (mb_resp),
    .device_id  (device_id),
    .pps_select (pps_select)
  );

  x4xx_timekeeper timekeeper_i (
    .radio_clk  (radio_clk),
    .rst_n      (rst_n),
    .req        (tk_req),
    .time_stb   (radio_time_stb),
    .resp       (tk_resp),
    .radio_time (radio_time)
  );

  // --------------------
  // one timed gate per board
  for (genvar g = 0; g < `X4XX_NUM_DBOARDS; g++) begin : gen_db_gate
    x4xx_radio_ctrlport_gate gate_i (
      .radio_clk  (radio_clk),
      .rst_n      (rst_n),
      .s_req      (db_req[g]),
      .s_resp     (db_resp[g]),
      .radio_time (radio_time),
      .m_req      (m_ctrlport_radio_req[g]),
      .m_resp     (m_ctrlport_radio_resp[g])
    );
  end

endmodule

/* sim/x4xx_core_sva.sv */
// concurrent assertions on the ctrlport response and release protocol
// bound into the decoder and into every radio gate
`timescale 1ns/1ps

module x4xx_core_sva (
  input logic radio_clk,
  input logic rst_n,
  input logic resp_ack,
  input logic issue,    // new wr or rd pulse
  input logic waiting   // earlier request not yet acked
);

  // acks are single-cycle pulses
  ack_single: assert property (@(posedge radio_clk) disable iff (!rst_n)
    resp_ack |=> !resp_ack)
    else $error("ack held high for two cycles");

  no_issue_while_waiting: assert property (@(posedge radio_clk) disable iff (!rst_n)
    waiting |-> !issue)
    else $error("new request issued while an ack is outstanding");

  // first cycle out of reset is quiet
  no_ack_after_reset: assert property (@(posedge radio_clk)
    (rst_n && !$past(rst_n)) |-> !resp_ack)
    else $error("ack in the cycle after reset release");

endmodule

bind x4xx_radio_ctrlport_gate x4xx_core_sva gate_sva_i (
  .radio_clk (radio_clk),
  .rst_n     (rst_n),
  .resp_ack  (s_resp.ack),
  .issue     (m_req.wr | m_req.rd),
  .waiting   (wait_q)
);

// host side, one request in flight through the decoder
bind x4xx_ctrlport_decoder x4xx_core_sva decoder_sva_i (
  .radio_clk (radio_clk),
  .rst_n     (rst_n),
  .resp_ack  (s_resp.ack),
  .issue     (s_req.wr | s_req.rd),
  .waiting   (tgt_q != tgt_none)
);

/* sim/x4xx_core_checker.sv */
// reference model and comparison for the x4xx core
// models registers, radio time, timed release and response latency
`timescale 1ns/1ps
`include "x4xx_core_config.svh"

module x4xx_core_checker (
  input logic                                                  radio_clk,
  input logic                                                  rst_n,
  input x4xx_core_pkg::ctrlport_req_t                          s_req,
  input x4xx_core_pkg::ctrlport_resp_t                         s_resp,
  input logic [`X4XX_NUM_DBOARDS*2-1:0]                        rx_stb,
  input logic [63:0]                                           radio_time,
  input logic                                                  radio_time_stb,
  input logic [15:0]                                           device_id,
  input logic [1:0]                                            pps_select,
  input x4xx_core_pkg::ctrlport_req_t  [`X4XX_NUM_DBOARDS-1:0] m_req,
  input x4xx_core_pkg::ctrlport_resp_t [`X4XX_NUM_DBOARDS-1:0] m_resp,
  output int                                                   errors
);

  x4xx_core_pkg::ctrlport_req_t rreq;  // expected forwarded request
  logic [63:0] model_time;
  logic [63:0] load_val;
  logic [31:0] set_lo;
  logic [31:0] snap_hi;
  logic [31:0] scratch;
  logic [31:0] exp_data;
  logic [15:0] dev;
  logic [1:0]  pps;
  logic [1:0]  exp_status;
  logic        load_arm;
  logic        tk_cap;
  logic        busy;
  logic        is_radio;
  logic        r_fwd;
  logic [19:0] off;
  int          cyc;
  int          exp_cyc;
  int          r_arr;
  int          rboard;

  task automatic report(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  initial begin
    errors = 0;
    cyc    = 0;
  end

  always @(posedge radio_clk) begin
    cyc++;
    if (!rst_n) begin
      model_time = '0;
      dev        = `X4XX_DEVICE_ID_RESET;
      scratch    = '0;
      pps        = '0;
      busy       = 0;
      load_arm   = 0;
      tk_cap     = 0;
    end else begin
      if (radio_time !== model_time)
        report($sformatf("radio_time %0h, model %0h", radio_time, model_time));
      if (radio_time_stb !== rx_stb[0])
        report("radio_time_stb does not follow rx_stb[0]");
      if (tk_cap) begin  // NOW_LO read reaches the timekeeper now
        exp_data = model_time[31:0];
        snap_hi  = model_time[63:32];
        tk_cap   = 0;
      end
      // ---- board ports
      for (int n = 0; n < `X4XX_NUM_DBOARDS; n++) begin
        if (m_req[n].wr | m_req[n].rd) begin
          if (!(busy && is_radio && n == rboard && !r_fwd))
            report($sformatf("unexpected request on board %0d", n));
          else begin
            if (m_req[n] !== rreq)
              report($sformatf("board %0d request fields differ", n));
            if (cyc < r_arr + 2 || (rreq.has_time && model_time < rreq.timestamp))
              report($sformatf("board %0d request released early", n));
            r_fwd = 1;
          end
        end else if (busy && is_radio && n == rboard && !r_fwd && cyc >= r_arr + 2 &&
                     (!rreq.has_time || model_time >= rreq.timestamp))
          report($sformatf("board %0d request not released when due", n));
      end
      if (busy && is_radio && r_fwd && m_resp[rboard].ack)
        exp_cyc = cyc + 1;
      // ---- responses
      if (s_resp.ack) begin
        if (!busy)
          report("ack without a request");
        else begin
          if (cyc != exp_cyc)
            report($sformatf("ack latency off by %0d cycles", cyc - exp_cyc));
          if (s_resp.status !== exp_status || s_resp.data !== exp_data)
            report($sformatf("response %0d/%0h, expected %0d/%0h",
                             s_resp.status, s_resp.data, exp_status, exp_data));
          if (device_id !== dev || pps_select !== pps)
            report("device_id or pps_select output differs from model");
          busy = 0;
        end
      end else if (busy && cyc == exp_cyc)
        report("missing ack");
      // ---- time model, load replaces the increment
      if (load_arm)
        model_time = load_val;
      else if (rx_stb[0])
        model_time = model_time + 64'd1;
      load_arm = 0;
      // ---- new request
      if (s_req.wr | s_req.rd) begin
        busy       = 1;
        is_radio   = 0;
        exp_status = x4xx_core_pkg::sts_okay;
        exp_data   = '0;
        exp_cyc    = cyc + 3;
        off        = 20'(s_req.addr[11:0]);
        if (s_req.addr[19:12] == 8'h00) begin
          if (s_req.rd)
            case (off)
              `X4XX_REG_COMPAT:     exp_data = `X4XX_COMPAT_NUM;
              `X4XX_REG_DEVICE_ID:  exp_data = {16'b0, dev};
              `X4XX_REG_SCRATCH:    exp_data = scratch;
              `X4XX_REG_PPS_SELECT: exp_data = {30'b0, pps};
              default:              exp_data = '0;
            endcase
          else
            for (int b = 0; b < 4; b++)
              if (s_req.byte_en[b]) begin
                if (off == `X4XX_REG_DEVICE_ID && b < 2)
                  dev[8*b +: 8] = s_req.data[8*b +: 8];
                if (off == `X4XX_REG_SCRATCH)
                  scratch[8*b +: 8] = s_req.data[8*b +: 8];
                if (off == `X4XX_REG_PPS_SELECT && b == 0)
                  pps = s_req.data[1:0];
              end
        end else if (s_req.addr[19:12] == 8'h01) begin
          if (s_req.rd && off == `X4XX_REG_TIME_NOW_LO)
            tk_cap = 1;
          if (s_req.rd && off == `X4XX_REG_TIME_NOW_HI)
            exp_data = snap_hi;
          if (s_req.wr && off == `X4XX_REG_TIME_SET_LO)
            set_lo = s_req.data;
          if (s_req.wr && off == `X4XX_REG_TIME_SET_HI) begin
            load_arm = 1;
            load_val = {s_req.data, set_lo};
          end
        end else if (s_req.addr >= `X4XX_DB_BASE) begin
          is_radio  = 1;
          r_fwd     = 0;
          r_arr     = cyc;
          exp_cyc   = -1;
          off       = s_req.addr - `X4XX_DB_BASE;
          rboard    = int'(off >> `X4XX_DB_WINDOW_W);
          rreq      = s_req;
          rreq.addr = off & 20'h3FFFF;
          exp_data  = (32'(rreq.addr) ^ 32'hDB000000) + 32'(rboard);
        end else begin
          exp_status = x4xx_core_pkg::sts_cmderr;
          exp_cyc    = cyc + 1;
        end
      end
    end
  end

endmodule

/* sim/x4xx_core_tb.sv */
// testbench for the x4xx core control path
// clock, reset, LFSR stimulus, daughterboard responders, timeout, report
`timescale 1ns/1ps
`include "x4xx_core_config.svh"

module x4xx_core_tb;

  localparam int nb        = `X4XX_NUM_DBOARDS;
  localparam int num_reqs  = 24 + 32 + 16 + 16 + 12;
  localparam int max_ahead = 23;                         // largest timed delay, ticks
  localparam int limit     = num_reqs * (4 * max_ahead + 10) + 200;

  logic radio_clk = 0;
  logic rst_n     = 0;
  logic [nb*2-1:0] rx_stb = '0;
  logic [63:0] radio_time;
  logic        radio_time_stb;
  logic [15:0] device_id;
  logic [1:0]  pps_select;
  x4xx_core_pkg::ctrlport_req_t                s_req = '0;
  x4xx_core_pkg::ctrlport_resp_t               s_resp;
  x4xx_core_pkg::ctrlport_req_t  [nb-1:0]      m_req;
  x4xx_core_pkg::ctrlport_resp_t [nb-1:0]      m_resp = '0;
  logic [31:0] st_main = 72337;
  logic [31:0] st_stb  = 72337;
  logic [31:0] st_db   = 72337;
  logic [63:0] v;
  logic [63:0] rv;  // draws of the strobe and responder block
  int errors;
  int cycles    = 0;
  int sent      = 0;
  int prev_err  = 0;
  int prev_sent = 0;
  int cnt [nb];
  logic [19:0] db_addr [nb];
  logic [nb-1:0] fire_s;

  always #5 radio_clk = ~radio_clk;

  x4xx_core UUT (
    .radio_clk (radio_clk), .rst_n (rst_n),
    .s_ctrlport_req (s_req), .s_ctrlport_resp (s_resp),
    .rx_stb (rx_stb), .radio_time (radio_time), .radio_time_stb (radio_time_stb),
    .device_id (device_id), .pps_select (pps_select),
    .m_ctrlport_radio_req (m_req), .m_ctrlport_radio_resp (m_resp)
  );

  x4xx_core_checker checker_i (
    .radio_clk (radio_clk), .rst_n (rst_n), .s_req (s_req), .s_resp (s_resp),
    .rx_stb (rx_stb), .radio_time (radio_time), .radio_time_stb (radio_time_stb),
    .device_id (device_id), .pps_select (pps_select), .m_req (m_req),
    .m_resp (m_resp), .errors (errors)
  );

  // galois LFSR, one step per bit
  task automatic draw(inout logic [31:0] st, input int nbits, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      st  = st[0] ? ((st >> 1) ^ 32'h80200003) : (st >> 1);
      val = {val[62:0], st[0]};
    end
  endtask

  task automatic send(input logic wr, input logic [19:0] addr, input logic [31:0] data,
                      input logic [3:0] be, input logic has_time, input logic [63:0] ts);
    s_req = '{wr: wr, rd: !wr, addr: addr, data: data, byte_en: be,
              has_time: has_time, timestamp: ts};
    @(posedge radio_clk);
    #1 s_req.wr = 0;
    s_req.rd = 0;
    sent++;
    do @(posedge radio_clk); while (!s_resp.ack);
    #1;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d requests, %0d errors", name, sent - prev_sent, errors - prev_err);
    prev_sent = sent;
    prev_err  = errors;
  endtask

  // ---- random strobes and board responders
  always @(posedge radio_clk) begin
    for (int n = 0; n < nb; n++) begin
      fire_s[n]  = m_req[n].wr | m_req[n].rd;
      db_addr[n] = fire_s[n] ? m_req[n].addr : db_addr[n];
    end
    #1;
    draw(st_stb, nb * 2, rv);
    rx_stb = rv[nb*2-1:0];
    for (int n = 0; n < nb; n++) begin
      m_resp[n] = '0;
      if (fire_s[n]) begin
        draw(st_db, 2, rv);
        cnt[n] = int'(rv[1:0]) + 1;  // 1 to 4 cycles
      end
      if (cnt[n] > 0) begin
        cnt[n]--;
        if (cnt[n] == 0) begin
          m_resp[n].ack  = 1;
          m_resp[n].data = (32'(db_addr[n]) ^ 32'hDB000000) + 32'(n);
        end
      end
    end
  end

  // timeout watchdog
  always @(posedge radio_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  // --------------------
  // test sequence
  initial begin
    for (int n = 0; n < nb; n++)
      cnt[n] = 0;
    repeat (5) @(posedge radio_clk);
    #1 rst_n = 1;
    @(posedge radio_clk);
    #1;
    for (int i = 0; i < 24; i++) begin
      draw(st_main, 39, v);
      send(v[38], 20'(v[37:36]) << 2, v[31:0], v[35:32], 0, '0);
    end
    end_test("mb_regs");
    // low word just below the wrap, so the high word can change between reads
    for (int i = 0; i < 8; i++) begin
      draw(st_main, 36, v);
      send(1, `X4XX_TK_BASE + `X4XX_REG_TIME_SET_LO, 32'hFFFFFFFC + 32'(v[1:0]), 4'hF, 0, '0);
      send(1, `X4XX_TK_BASE + `X4XX_REG_TIME_SET_HI, v[35:4], 4'hF, 0, '0);
      send(0, `X4XX_TK_BASE + `X4XX_REG_TIME_NOW_LO, '0, 4'hF, 0, '0);
      send(0, `X4XX_TK_BASE + `X4XX_REG_TIME_NOW_HI, '0, 4'hF, 0, '0);
    end
    end_test("timekeeper");
    for (int i = 0; i < 16; i++) begin
      draw(st_main, 56, v);
      send(v[55], `X4XX_DB_BASE + (20'(v[54]) << `X4XX_DB_WINDOW_W) + 20'(v[49:32]),
           v[31:0], v[53:50], 0, '0);
    end
    end_test("radio_untimed");
    for (int i = 0; i < 16; i++) begin
      draw(st_main, 61, v);
      send(v[60], `X4XX_DB_BASE + (20'(v[59]) << `X4XX_DB_WINDOW_W) + 20'(v[40:23]),
           v[31:0], v[58:55], 1, radio_time + 64'(v[54:50]) - 64'd8);  // some already late
    end
    end_test("radio_timed");
    for (int i = 0; i < 12; i++) begin
      draw(st_main, 20, v);
      send(v[19], 20'h02000 + 20'(v[18:0] % 19'h7E000), 32'h5A5A0000, 4'hF, 0, '0);
    end
    end_test("unmapped");
    repeat (4) @(posedge radio_clk);
    $display("summary: %0d requests, %0d errors", sent, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* sources.f */
+incdir+rtl
rtl/x4xx_core_pkg.sv
rtl/x4xx_ctrlport_decoder.sv
rtl/x4xx_mb_regs.sv
rtl/x4xx_timekeeper.sv
rtl/x4xx_radio_ctrlport_gate.sv
rtl/x4xx_core.sv
sim/x4xx_core_sva.sv
sim/x4xx_core_checker.sv
sim/x4xx_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the x4xx core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module x4xx_core_tb -f sources.f

out=$(./obj_dir/Vx4xx_core_tb)
echo "$out"
echo "$out" | grep -q "^TEST PASS$"
